// ==== Bender.yml ====
package:
  name: cgra

sources:
  - files:
      - src/cgra_pkg.sv
      - src/switch_box.sv
      - src/connection_box.sv
      - src/pe_core.sv
      - src/cgra_tile.sv
      - src/config_loader.sv
      - src/cgra_array.sv
  - target: test
    files:
      - bench/cgra_tb.sv

// ==== bench/cgra_tb.sv ====
// CGRA array testbench
`timescale 1ns/10ps

module cgra_tb;

   import cgra_pkg::*;

   logic        clk = 1'b0;
   logic        rst;
   logic        req_valid;
   logic        req_ready;
   cfg_req_t    cfg_req;
   logic        rsp_valid;
   logic        rsp_ready;
   cfg_rsp_t    rsp;
   array_edge_t edge_in;
   array_edge_t edge_out;

   logic [31:0] seed = 32'd81;
   logic [31:0] exp_sb [num_tiles];
   logic [31:0] exp_pe [num_tiles];

   cgra_array cgra_array_inst (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .cfg_req   (cfg_req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp),
      .edge_in   (edge_in),
      .edge_out  (edge_out)
   );

   always #10 clk = ~clk;

   task automatic report_fail(input string what);
      $display("Test failures found");
      $display("%s", what);
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else report_fail($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
   endtask

   // Response must hold while back-pressured
   assert property (@(posedge clk) disable iff (!rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
   else report_fail("Response changed or dropped while rsp_ready was low");

   assert property (@(posedge clk) disable iff (!rst) rsp_valid |-> !req_ready)
   else report_fail("req_ready was high while a response was pending");

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // All-zero routing sends every track across to the opposite edge
   function automatic array_edge_t straight_out(input array_edge_t e);
      array_edge_t o;
      o.side_0 = e.side_2;
      o.side_1 = e.side_3;
      o.side_2 = e.side_0;
      o.side_3 = e.side_1;
      return o;
   endfunction

   function automatic logic pe_expect(input pe_op_t op, input logic a, input logic b);
      case (op)
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         default: return a;
      endcase
   endfunction

   task automatic count_wait(inout int n, input string what);
      n++;
      if (n > 100) begin
         report_fail($sformatf("Timeout while waiting for %s", what));
      end
   endtask

   task automatic present(input cfg_req_t r);
      @(posedge clk);
      req_valid <= 1'b1;
      cfg_req   <= r;
   endtask

   // Returns on the accepting edge
   task automatic wait_accept();
      int n;
      n = 0;
      @(negedge clk);
      while (!req_ready) begin
         count_wait(n, "req_ready");
         @(negedge clk);
      end
      @(posedge clk);
      req_valid <= 1'b0;
   endtask

   task automatic wait_rsp();
      int n;
      n = 0;
      @(negedge clk);
      while (!rsp_valid) begin
         count_wait(n, "rsp_valid");
         @(negedge clk);
      end
   endtask

   // Taken on the second edge
   task automatic release_rsp();
      @(posedge clk);
      rsp_ready <= 1'b1;
      @(posedge clk);
      rsp_ready <= 1'b0;
   endtask

   task automatic write_word(input int tile, input cfg_target_t tg, input logic [31:0] w);
      cfg_req_t r;
      int       n;
      r.write    = 1'b1;
      r.tile     = tile[1:0];
      r.target   = tg;
      r.data.raw = w;
      present(r);
      wait_accept();
      // New word is in place once the loader is ready again
      n = 0;
      @(negedge clk);
      while (!req_ready) begin
         count_wait(n, "end of write");
         @(negedge clk);
      end
   endtask

   task automatic read_word(input int tile, input cfg_target_t tg, input logic [31:0] exp);
      cfg_req_t r;
      r          = '0;
      r.tile     = tile[1:0];
      r.target   = tg;
      present(r);
      wait_accept();
      wait_rsp();
      check_val("rsp.data", exp, rsp.data.raw);
      release_rsp();
      @(negedge clk);
      check_val("rsp_valid", 32'd0, rsp_valid);
   endtask

   task automatic drive_edge(input array_edge_t e);
      @(posedge clk);
      edge_in <= e;
      @(negedge clk);
   endtask

   initial begin
      array_edge_t e;
      array_edge_t prev;
      array_edge_t exp_e;
      cfg_word_u   w;
      cfg_req_t    r;
      int          hold;
      int          tile;
      int          next;

      rst       = 1'b0;
      req_valid = 1'b0;
      cfg_req   = '0;
      rsp_ready = 1'b0;
      edge_in   = '0;
      repeat (2) @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      check_val("req_ready", 32'd1, req_ready);
      check_val("rsp_valid", 32'd0, rsp_valid);

      for (int i = 0; i < 8; i++) begin
         e = lcg_next();
         drive_edge(e);
         check_val("edge_out", straight_out(e), edge_out);
      end

      // Only one tile leaves straight routing at a time, so no loops
      for (int t = 0; t < num_tiles; t++) begin
         exp_sb[t] = lcg_next();
         exp_pe[t] = lcg_next();
         write_word(t, target_sb, exp_sb[t]);
         write_word(t, target_pe, exp_pe[t]);
         read_word(t, target_sb, exp_sb[t]);
         read_word(t, target_pe, exp_pe[t]);
         write_word(t, target_sb, 32'd0);
      end

      // Back-pressure with the next read already waiting
      r        = '0;
      r.target = target_pe;
      tile     = 2;
      r.tile   = 2'd2;
      present(r);
      wait_accept();
      for (int i = 0; i < 6; i++) begin
         wait_rsp();
         check_val("rsp.data", exp_pe[tile], rsp.data.raw);
         hold   = lcg_next() % 5 + 1;
         next   = (tile == 2) ? 3 : 2;
         r.tile = next[1:0];
         present(r);
         repeat (hold) begin
            @(negedge clk);
            check_val("rsp_valid", 32'd1, rsp_valid);
            check_val("rsp.data", exp_pe[tile], rsp.data.raw);
            check_val("req_ready", 32'd0, req_ready);
         end
         release_rsp();
         wait_accept();
         tile = next;
      end
      wait_rsp();
      check_val("rsp.data", exp_pe[tile], rsp.data.raw);
      release_rsp();

      // Tile 0 south outputs turn to the east inputs
      write_word(0, target_sb, 32'h0000_0055);
      for (int i = 0; i < 6; i++) begin
         e = lcg_next();
         drive_edge(e);
         exp_e             = straight_out(e);
         exp_e.side_0[3:0] = e.side_1[3:0];
         check_val("edge_out", exp_e, edge_out);
      end

      // West track 0 out from the PE, operands on west tracks 1 and 2
      write_word(0, target_sb, 32'h0300_0000);
      for (int op = 0; op < 4; op++) begin
         w          = '0;
         w.pe.op    = pe_op_t'(op);
         w.pe.sel_a = 4'd13;
         w.pe.sel_b = 4'd14;
         write_word(0, target_pe, w.raw);
         for (int i = 0; i < 6; i++) begin
            e = lcg_next();
            drive_edge(e);
            check_val("edge_out.side_3[0]",
                      pe_expect(pe_op_t'(op), e.side_3[1], e.side_3[2]), edge_out.side_3[0]);
         end
         w.pe.out_reg = 1'b1;
         write_word(0, target_pe, w.raw);
         prev = lcg_next();
         drive_edge(prev);
         for (int i = 0; i < 6; i++) begin
            e = lcg_next();
            drive_edge(e);
            check_val("edge_out.side_3[0]",
                      pe_expect(pe_op_t'(op), prev.side_3[1], prev.side_3[2]),
                      edge_out.side_3[0]);
            prev = e;
         end
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== list.f ====
src/cgra_pkg.sv
src/switch_box.sv
src/connection_box.sv
src/pe_core.sv
src/cgra_tile.sv
src/config_loader.sv
src/cgra_array.sv
bench/cgra_tb.sv

// ==== src/cgra_array.sv ====
// CGRA array top level
`timescale 1ns/10ps

module cgra_array (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  cgra_pkg::cfg_req_t    cfg_req,
   output logic                  rsp_valid,
   input  logic                  rsp_ready,
   output cgra_pkg::cfg_rsp_t    rsp,
   input  cgra_pkg::array_edge_t edge_in,
   output cgra_pkg::array_edge_t edge_out
);

   import cgra_pkg::*;

   localparam int tps = tracks_per_side;

   cfg_word_u              cfg_data;
   logic [num_tiles-1:0]   sb_we;
   logic [num_tiles-1:0]   pe_we;
   sb_cfg_t                sb_cfg_all [num_tiles];
   pe_cfg_t                pe_cfg_all [num_tiles];
   tile_tracks_t           tile_in    [num_tiles];
   tile_tracks_t           tile_out   [num_tiles];

   config_loader config_loader_inst (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .cfg_req    (cfg_req),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp        (rsp),
      .cfg_data   (cfg_data),
      .sb_we      (sb_we),
      .pe_we      (pe_we),
      .sb_cfg_all (sb_cfg_all),
      .pe_cfg_all (pe_cfg_all)
   );

   // Tile index is row * array_dim + col, row 0 at the south
   for (genvar r = 0; r < array_dim; r++) begin : g_row
      for (genvar c = 0; c < array_dim; c++) begin : g_col
         localparam int idx = r * array_dim + c;

         cgra_tile cgra_tile_inst (
            .clk       (clk),
            .rst       (rst),
            .cfg_data  (cfg_data),
            .sb_we     (sb_we[idx]),
            .pe_we     (pe_we[idx]),
            .track_in  (tile_in[idx]),
            .track_out (tile_out[idx]),
            .sb_cfg    (sb_cfg_all[idx]),
            .pe_cfg    (pe_cfg_all[idx])
         );

         // South side
         if (r == 0) begin : g_south_edge
            assign tile_in[idx].side_0          = edge_in.side_0[c*tps +: tps];
            assign edge_out.side_0[c*tps +: tps] = tile_out[idx].side_0;
         end else begin : g_south_link
            assign tile_in[idx].side_0 = tile_out[idx - array_dim].side_2;
         end

         // North side
         if (r == array_dim - 1) begin : g_north_edge
            assign tile_in[idx].side_2          = edge_in.side_2[c*tps +: tps];
            assign edge_out.side_2[c*tps +: tps] = tile_out[idx].side_2;
         end else begin : g_north_link
            assign tile_in[idx].side_2 = tile_out[idx + array_dim].side_0;
         end

         // East side
         if (c == array_dim - 1) begin : g_east_edge
            assign tile_in[idx].side_1          = edge_in.side_1[r*tps +: tps];
            assign edge_out.side_1[r*tps +: tps] = tile_out[idx].side_1;
         end else begin : g_east_link
            assign tile_in[idx].side_1 = tile_out[idx + 1].side_3;
         end

         // West side
         if (c == 0) begin : g_west_edge
            assign tile_in[idx].side_3          = edge_in.side_3[r*tps +: tps];
            assign edge_out.side_3[r*tps +: tps] = tile_out[idx].side_3;
         end else begin : g_west_link
            assign tile_in[idx].side_3 = tile_out[idx - 1].side_1;
         end
      end
   end

endmodule

// ==== src/cgra_pkg.sv ====
// CGRA shared definitions

package cgra_pkg;

   // Fabric geometry
   localparam int tracks_per_side = 4;
   localparam int num_sides       = 4;
   localparam int array_dim       = 2;
   localparam int num_tiles       = 4;

   // Tracks of one tile, side 0 south, 1 east, 2 north, 3 west
   typedef struct packed {
      logic [3:0] side_3;
      logic [3:0] side_2;
      logic [3:0] side_1;
      logic [3:0] side_0;
   } tile_tracks_t;

   // Array boundary, lower nibble is column 0 or row 0
   typedef struct packed {
      logic [7:0] side_3;
      logic [7:0] side_2;
      logic [7:0] side_1;
      logic [7:0] side_0;
   } array_edge_t;

   // Source of one switch output on side s
   typedef enum logic [1:0] {
      route_opp  = 2'd0,  // side s+2
      route_next = 2'd1,  // side s+1
      route_prev = 2'd2,  // side s+3
      route_pe   = 2'd3
   } route_opt_t;

   // Entry 0 is side 0 track 0
   typedef struct packed {
      route_opt_t [15:0] route;
   } sb_cfg_t;

   typedef enum logic [1:0] {
      op_and    = 2'd0,
      op_or     = 2'd1,
      op_xor    = 2'd2,
      op_pass_a = 2'd3
   } pe_op_t;

   typedef struct packed {
      logic [19:0] unused;
      logic        out_reg;
      pe_op_t      op;
      logic [3:0]  sel_b;
      logic [3:0]  sel_a;
      logic        reserved;
   } pe_cfg_t;

   // One config word, view picked by the request target
   typedef union packed {
      sb_cfg_t     sb;
      pe_cfg_t     pe;
      logic [31:0] raw;
   } cfg_word_u;

   typedef enum logic {
      target_sb = 1'b0,
      target_pe = 1'b1
   } cfg_target_t;

   typedef struct packed {
      logic        write;
      logic [1:0]  tile;
      cfg_target_t target;
      cfg_word_u   data;
   } cfg_req_t;

   typedef struct packed {
      cfg_word_u data;
   } cfg_rsp_t;

endpackage

// ==== src/cgra_tile.sv ====
// CGRA tile
`timescale 1ns/10ps

module cgra_tile (
   input  logic                   clk,
   input  logic                   rst,
   input  cgra_pkg::cfg_word_u    cfg_data,
   input  logic                   sb_we,
   input  logic                   pe_we,
   input  cgra_pkg::tile_tracks_t track_in,
   output cgra_pkg::tile_tracks_t track_out,
   output cgra_pkg::sb_cfg_t      sb_cfg,
   output cgra_pkg::pe_cfg_t      pe_cfg
);

   import cgra_pkg::*;

   logic opnd_a;
   logic opnd_b;
   logic pe_out;

   switch_box switch_box_inst (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (sb_we),
      .cfg_data  (cfg_data),
      .track_in  (track_in),
      .pe_out    (pe_out),
      .track_out (track_out),
      .sb_cfg    (sb_cfg)
   );

   // Operand selects come straight from the PE config word
   connection_box connection_box_inst (
      .track_in (track_in),
      .sel_a    (pe_cfg.sel_a),
      .sel_b    (pe_cfg.sel_b),
      .opnd_a   (opnd_a),
      .opnd_b   (opnd_b)
   );

   pe_core pe_core_inst (
      .clk      (clk),
      .rst      (rst),
      .cfg_we   (pe_we),
      .cfg_data (cfg_data),
      .opnd_a   (opnd_a),
      .opnd_b   (opnd_b),
      .pe_cfg   (pe_cfg),
      .pe_out   (pe_out)
   );

endmodule

// ==== src/config_loader.sv ====
// Configuration loader
`timescale 1ns/10ps

module config_loader (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           req_valid,
   output logic                           req_ready,
   input  cgra_pkg::cfg_req_t             cfg_req,
   output logic                           rsp_valid,
   input  logic                           rsp_ready,
   output cgra_pkg::cfg_rsp_t             rsp,
   output cgra_pkg::cfg_word_u            cfg_data,
   output logic [cgra_pkg::num_tiles-1:0] sb_we,
   output logic [cgra_pkg::num_tiles-1:0] pe_we,
   input  cgra_pkg::sb_cfg_t              sb_cfg_all [cgra_pkg::num_tiles],
   input  cgra_pkg::pe_cfg_t              pe_cfg_all [cgra_pkg::num_tiles]
);

   import cgra_pkg::*;

   cfg_req_t  req_q;
   logic      busy_q;
   cfg_word_u rd_word;

   // Held request, only meaningful while busy
   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         req_q <= cfg_req;
      end
   end

   // Busy for exactly the cycle after acceptance
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         busy_q    <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         busy_q <= req_valid && req_ready;
         if (busy_q && !req_q.write) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   assign req_ready = !busy_q && !rsp_valid;
   assign cfg_data  = req_q.data;

   // One-hot write enable for the addressed tile and target
   always_comb begin
      sb_we = '0;
      pe_we = '0;
      if (busy_q && req_q.write) begin
         if (req_q.target == target_sb) begin
            sb_we[req_q.tile] = 1'b1;
         end else begin
            pe_we[req_q.tile] = 1'b1;
         end
      end
   end

   always_comb begin
      if (req_q.target == target_sb) begin
         rd_word.sb = sb_cfg_all[req_q.tile];
      end else begin
         rd_word.pe = pe_cfg_all[req_q.tile];
      end
   end

   // Response word holds until taken
   always_ff @(posedge clk) begin
      if (busy_q && !req_q.write) begin
         rsp.data <= rd_word;
      end
   end

endmodule

// ==== src/connection_box.sv ====
// PE operand connection box
`timescale 1ns/10ps

module connection_box (
   input  cgra_pkg::tile_tracks_t track_in,
   input  logic [3:0]             sel_a,
   input  logic [3:0]             sel_b,
   output logic                   opnd_a,
   output logic                   opnd_b
);

   import cgra_pkg::*;

   // Track i is side i/4, track i%4
   logic [num_sides*tracks_per_side-1:0] flat;

   assign flat = track_in;

   // Two independent 16-to-1 selectors
   assign opnd_a = flat[sel_a];
   assign opnd_b = flat[sel_b];

endmodule

// ==== src/pe_core.sv ====
// One-bit processing element
`timescale 1ns/10ps

module pe_core (
   input  logic                clk,
   input  logic                rst,
   input  logic                cfg_we,
   input  cgra_pkg::cfg_word_u cfg_data,
   input  logic                opnd_a,
   input  logic                opnd_b,
   output cgra_pkg::pe_cfg_t   pe_cfg,
   output logic                pe_out
);

   import cgra_pkg::*;

   pe_cfg_t cfg_q;
   logic    res;
   logic    res_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         cfg_q <= '0;
      end else if (cfg_we) begin
         cfg_q <= cfg_data.pe;
      end
   end

   always_comb begin
      case (cfg_q.op)
         op_and: begin
            res = opnd_a & opnd_b;
         end
         op_or: begin
            res = opnd_a | opnd_b;
         end
         op_xor: begin
            res = opnd_a ^ opnd_b;
         end
         default: begin
            res = opnd_a;
         end
      endcase
   end

   // Optional output stage, always clocked
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         res_q <= 1'b0;
      end else begin
         res_q <= res;
      end
   end

   assign pe_out = cfg_q.out_reg ? res_q : res;
   assign pe_cfg = cfg_q;

endmodule

// ==== src/switch_box.sv ====
// Tile switch box
`timescale 1ns/10ps

// Layout of the four sides
//
//              2
//
//      3   switch_box   1
//
//              0

module switch_box (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cfg_we,
   input  cgra_pkg::cfg_word_u    cfg_data,
   input  cgra_pkg::tile_tracks_t track_in,
   input  logic                   pe_out,
   output cgra_pkg::tile_tracks_t track_out,
   output cgra_pkg::sb_cfg_t      sb_cfg
);

   import cgra_pkg::*;

   // 16 switches, 2 bits each
   sb_cfg_t cfg_q;

   // Indexed as [side][track]
   logic [num_sides-1:0][tracks_per_side-1:0] in_vec;
   logic [num_sides-1:0][tracks_per_side-1:0] out_vec;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         cfg_q <= '0;
      end else if (cfg_we) begin
         cfg_q <= cfg_data.sb;
      end
   end

   assign in_vec = track_in;

   // Each output takes the same track number from another side
   always_comb begin
      for (int s = 0; s < num_sides; s++) begin
         for (int t = 0; t < tracks_per_side; t++) begin
            case (cfg_q.route[s * tracks_per_side + t])
               route_opp: begin
                  out_vec[s][t] = in_vec[(s + 2) % num_sides][t];
               end
               route_next: begin
                  out_vec[s][t] = in_vec[(s + 1) % num_sides][t];
               end
               route_prev: begin
                  out_vec[s][t] = in_vec[(s + 3) % num_sides][t];
               end
               default: begin
                  out_vec[s][t] = pe_out;
               end
            endcase
         end
      end
   end

   assign track_out = out_vec;
   assign sb_cfg    = cfg_q;

endmodule
